/* src/smbus_pkg.sv */
// SMBus PEC receiver definitions
package smbus_pkg;

    // Bits per SMBus byte
    localparam int unsigned BYTE_W = 8;

    // Address, command, data low, data high and PEC
    localparam int unsigned PKT_BYTES = 5;

    // CRC-8 as used by the SMBus Packet Error Code
    localparam logic [BYTE_W-1:0] CRC8_POLY = 8'h07;
    localparam logic [BYTE_W-1:0] CRC8_INIT = 8'h00;

    // SCL low limit in clk cycles, scaled down from 25 ms
    localparam int unsigned TIMEOUT_CYCLES = 4000;
    localparam int unsigned TIMEOUT_CNT_W = 13;

    // Byte position inside one transaction, saturates at 7
    typedef logic [2:0] byte_idx_t;

    // Positions of the write-word fields
    localparam byte_idx_t IDX_ADDR = 3'd0;
    localparam byte_idx_t IDX_CMD = 3'd1;
    localparam byte_idx_t IDX_DATA_LO = 3'd2;
    localparam byte_idx_t IDX_DATA_HI = 3'd3;
    localparam byte_idx_t IDX_PEC = 3'd4;

    // First byte after START, address in the upper seven bits
    typedef struct packed {
        logic [6:0] addr;
        logic       rw;
    } smbus_addr_t;

    // One received byte, seen raw or as address plus R/W
    typedef union packed {
        logic [BYTE_W-1:0] raw;
        smbus_addr_t       a;
    } smbus_byte_u;

endpackage

/* src/smbus_line_sampler.sv */
// SMBus line sampler
`timescale 1ns/1ps

module smbus_line_sampler (
    input  logic clk,
    input  logic rst_sync_n,
    input  logic sda,
    input  logic scl,
    output logic scl_low,
    output logic bit_strobe,
    output logic bit_value,
    output logic start_det,
    output logic stop_det
);

    // Two-stage synchronizers on both pins
    logic sda_s1;
    logic sda_s2;
    logic scl_s1;
    logic scl_s2;

    // Previous synchronized levels
    logic sda_d;
    logic scl_d;

    // Edge conditions on the synchronized lines
    logic scl_rise;
    logic start_cond;
    logic stop_cond;

    // SCL going high marks a data bit
    assign scl_rise = scl_s2 & ~scl_d;

    // SDA falling while SCL stays high is a START or repeated START
    assign start_cond = scl_s2 & scl_d & sda_d & ~sda_s2;

    // SDA rising while SCL stays high is a STOP
    assign stop_cond = scl_s2 & scl_d & ~sda_d & sda_s2;

    // Level used by the timeout monitor
    assign scl_low = ~scl_s2;

    // Idle bus reads high on both lines
    always_ff @(posedge clk) begin
        if (!rst_sync_n) begin
            sda_s1     <= 1'b1;
            sda_s2     <= 1'b1;
            scl_s1     <= 1'b1;
            scl_s2     <= 1'b1;
            sda_d      <= 1'b1;
            scl_d      <= 1'b1;
            bit_strobe <= 1'b0;
            start_det  <= 1'b0;
            stop_det   <= 1'b0;
        end else begin
            sda_s1     <= sda;
            sda_s2     <= sda_s1;
            scl_s1     <= scl;
            scl_s2     <= scl_s1;
            sda_d      <= sda_s2;
            scl_d      <= scl_s2;
            // Registered pulses, one cycle each
            bit_strobe <= scl_rise;
            start_det  <= start_cond;
            stop_det   <= stop_cond;
        end
    end

    // Data bit is SDA as seen at the SCL rise
    always_ff @(posedge clk) begin
        if (scl_rise) begin
            bit_value <= sda_s2;
        end
    end

endmodule

/* src/smbus_byte_framer.sv */
// SMBus byte framer
`timescale 1ns/1ps

module smbus_byte_framer (
    input  logic                     clk,
    input  logic                     rst_sync_n,
    input  logic                     bit_strobe,
    input  logic                     bit_value,
    input  logic                     start_det,
    input  logic                     timeout_det,
    output logic                     byte_valid,
    output smbus_pkg::smbus_byte_u   byte_data,
    output smbus_pkg::byte_idx_t     byte_idx
);

    import smbus_pkg::*;

    // Slots 0 to 7 carry data, slot 8 is the ACK
    logic [3:0]        slot_cnt;
    logic [BYTE_W-1:0] shift_q;
    logic              last_data_slot;
    logic              ack_slot;

    assign last_data_slot = (slot_cnt == 4'(BYTE_W - 1));
    assign ack_slot       = (slot_cnt == 4'(BYTE_W));

    // Slot counter and byte release strobe
    always_ff @(posedge clk) begin
        if (!rst_sync_n) begin
            slot_cnt   <= 4'd0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (start_det || timeout_det) begin
                // Realign to a fresh byte boundary
                slot_cnt <= 4'd0;
            end else if (bit_strobe) begin
                if (ack_slot) begin
                    // ACK bit is dropped
                    slot_cnt <= 4'd0;
                end else begin
                    slot_cnt <= slot_cnt + 4'd1;
                    if (last_data_slot) begin
                        byte_valid <= 1'b1;
                    end
                end
            end
        end
    end

    // Byte position, held during byte_valid and bumped afterwards
    always_ff @(posedge clk) begin
        if (!rst_sync_n) begin
            byte_idx <= '0;
        end else if (start_det) begin
            byte_idx <= '0;
        end else if (byte_valid && (byte_idx != '1)) begin
            // Saturate so an overrun stays visible
            byte_idx <= byte_idx + 3'd1;
        end
    end

    // MSB first shift, last data bit goes straight into the output byte
    always_ff @(posedge clk) begin
        if (bit_strobe && !ack_slot) begin
            shift_q <= {shift_q[BYTE_W-2:0], bit_value};
        end
        if (bit_strobe && last_data_slot) begin
            byte_data.raw <= {shift_q[BYTE_W-2:0], bit_value};
        end
    end

endmodule

/* src/smbus_timeout_monitor.sv */
// SMBus SCL low timeout monitor
`timescale 1ns/1ps

module smbus_timeout_monitor (
    input  logic clk,
    input  logic rst_sync_n,
    input  logic scl_low,
    output logic timeout_det
);

    import smbus_pkg::*;

    // Consecutive SCL low cycles, stops at the limit
    logic [TIMEOUT_CNT_W-1:0] low_cnt;

    always_ff @(posedge clk) begin
        if (!rst_sync_n) begin
            low_cnt     <= '0;
            timeout_det <= 1'b0;
        end else begin
            timeout_det <= 1'b0;
            if (!scl_low) begin
                // Any high SCL restarts the count
                low_cnt <= '0;
            end else if (low_cnt != TIMEOUT_CNT_W'(TIMEOUT_CYCLES)) begin
                low_cnt <= low_cnt + 1'b1;
                // Single pulse as the count reaches the limit
                if (low_cnt == TIMEOUT_CNT_W'(TIMEOUT_CYCLES - 1)) begin
                    timeout_det <= 1'b1;
                end
            end
        end
    end

endmodule

/* src/smbus_packet_assembler.sv */
// SMBus write-word packet assembler
`timescale 1ns/1ps

module smbus_packet_assembler (
    input  logic                     clk,
    input  logic                     rst_sync_n,
    input  logic                     byte_valid,
    input  smbus_pkg::smbus_byte_u   byte_data,
    input  smbus_pkg::byte_idx_t     byte_idx,
    input  logic                     start_det,
    input  logic                     stop_det,
    input  logic                     timeout_det,
    output logic                     pkt_valid,
    output logic [6:0]               pkt_addr,
    output logic [7:0]               pkt_command,
    output logic [15:0]              pkt_data,
    output logic                     crc_error,
    output logic                     format_error,
    output logic                     timeout_error
);

    import smbus_pkg::*;

    // Running PEC over address, command and data bytes
    logic [BYTE_W-1:0] crc_q;

    // Fields of the transaction in progress
    logic [6:0]        addr_q;
    logic              rw_q;
    logic [BYTE_W-1:0] cmd_q;
    logic [BYTE_W-1:0] data_lo_q;
    logic [BYTE_W-1:0] data_hi_q;
    logic [BYTE_W-1:0] pec_q;

    // Bytes seen since START, saturating
    byte_idx_t         byte_cnt;
    logic              frame_ok;

    // Whole byte per call, MSB first, same result as the bitwise form
    function automatic logic [BYTE_W-1:0] crc8_byte(
        input logic [BYTE_W-1:0] crc_in,
        input logic [BYTE_W-1:0] data
    );
        logic [BYTE_W-1:0] c;
        c = crc_in ^ data;
        for (int i = 0; i < BYTE_W; i++) begin
            c = c[BYTE_W-1] ? ((c << 1) ^ CRC8_POLY) : (c << 1);
        end
        return c;
    endfunction

    // Write-word shape with the write bit
    assign frame_ok = (byte_cnt == byte_idx_t'(PKT_BYTES)) && !rw_q;

    // CRC and byte count restart on every START
    always_ff @(posedge clk) begin
        if (!rst_sync_n) begin
            crc_q    <= CRC8_INIT;
            byte_cnt <= '0;
        end else if (start_det) begin
            crc_q    <= CRC8_INIT;
            byte_cnt <= '0;
        end else if (byte_valid) begin
            byte_cnt <= (byte_idx == '1) ? byte_idx : byte_idx + 3'd1;
            // PEC byte itself stays out of the sum
            if (byte_idx < IDX_PEC) begin
                crc_q <= crc8_byte(crc_q, byte_data.raw);
            end
        end
    end

    // Field capture by position
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            case (byte_idx)
                IDX_ADDR: begin
                    addr_q <= byte_data.a.addr;
                    rw_q   <= byte_data.a.rw;
                end
                IDX_CMD:     cmd_q     <= byte_data.raw;
                IDX_DATA_LO: data_lo_q <= byte_data.raw;
                IDX_DATA_HI: data_hi_q <= byte_data.raw;
                IDX_PEC:     pec_q     <= byte_data.raw;
                default: ;
            endcase
        end
    end

    // Outcome on STOP and timeout tracking
    always_ff @(posedge clk) begin
        if (!rst_sync_n) begin
            pkt_valid     <= 1'b0;
            crc_error     <= 1'b0;
            format_error  <= 1'b0;
            timeout_error <= 1'b0;
            pkt_addr      <= '0;
            pkt_command   <= '0;
            pkt_data      <= '0;
        end else begin
            pkt_valid    <= 1'b0;
            crc_error    <= 1'b0;
            format_error <= 1'b0;

            // Sticky until the next START
            if (timeout_det) begin
                timeout_error <= 1'b1;
            end else if (start_det) begin
                timeout_error <= 1'b0;
            end

            // A timed out transaction ends silently
            if (stop_det && !timeout_error && !timeout_det) begin
                if (frame_ok) begin
                    pkt_valid   <= 1'b1;
                    crc_error   <= (crc_q != pec_q);
                    pkt_addr    <= addr_q;
                    pkt_command <= cmd_q;
                    pkt_data    <= {data_hi_q, data_lo_q};
                end else begin
                    format_error <= 1'b1;
                end
            end
        end
    end

endmodule

/* src/smbus_pec_rx.sv */
// SMBus write-word receiver with PEC check
`timescale 1ns/1ps

module smbus_pec_rx (
    input  logic        clk,
    input  logic        rst_sync_n,
    input  logic        sda,
    input  logic        scl,
    output logic        pkt_valid,
    output logic [6:0]  pkt_addr,
    output logic [7:0]  pkt_command,
    output logic [15:0] pkt_data,
    output logic        crc_error,
    output logic        format_error,
    output logic        timeout_error
);

    import smbus_pkg::*;

    // Sampler to framer and timeout monitor
    logic        scl_low;
    logic        bit_strobe;
    logic        bit_value;
    logic        start_det;
    logic        stop_det;

    // Framer to assembler
    logic        byte_valid;
    smbus_byte_u byte_data;
    byte_idx_t   byte_idx;

    // Timeout monitor to framer and assembler
    logic        timeout_det;

    // Pin synchronization and bus condition detection
    smbus_line_sampler u_sampler (
        .clk        (clk),
        .rst_sync_n (rst_sync_n),
        .sda        (sda),
        .scl        (scl),
        .scl_low    (scl_low),
        .bit_strobe (bit_strobe),
        .bit_value  (bit_value),
        .start_det  (start_det),
        .stop_det   (stop_det)
    );

    // Bits to bytes
    smbus_byte_framer u_framer (
        .clk         (clk),
        .rst_sync_n  (rst_sync_n),
        .bit_strobe  (bit_strobe),
        .bit_value   (bit_value),
        .start_det   (start_det),
        .timeout_det (timeout_det),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .byte_idx    (byte_idx)
    );

    // Runs beside the framer on the SCL level
    smbus_timeout_monitor u_timeout (
        .clk         (clk),
        .rst_sync_n  (rst_sync_n),
        .scl_low     (scl_low),
        .timeout_det (timeout_det)
    );

    // Fields, PEC check and outcome
    smbus_packet_assembler u_assembler (
        .clk           (clk),
        .rst_sync_n    (rst_sync_n),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .byte_idx      (byte_idx),
        .start_det     (start_det),
        .stop_det      (stop_det),
        .timeout_det   (timeout_det),
        .pkt_valid     (pkt_valid),
        .pkt_addr      (pkt_addr),
        .pkt_command   (pkt_command),
        .pkt_data      (pkt_data),
        .crc_error     (crc_error),
        .format_error  (format_error),
        .timeout_error (timeout_error)
    );

endmodule

/* dv/tb_smbus_pec_rx.sv */
// SMBus PEC receiver testbench
`timescale 1ns/1ps

module tb_smbus_pec_rx;

    import smbus_pkg::*;

    // Clk cycles per SCL phase
    localparam int PHASE = 16;
    // 40 good, 10 bad PEC, 6 malformed, timeout pair, short hold
    localparam int N_TRANS = 59;
    localparam int LONG_HOLD = TIMEOUT_CYCLES + 100;
    localparam int SHORT_HOLD = TIMEOUT_CYCLES - 200;
    localparam int CYCLE_LIMIT = 2 * (N_TRANS * 6 * 9 * 32 + LONG_HOLD + SHORT_HOLD);

    logic        clk = 1'b0;
    logic        rst_sync_n;
    logic        sda;
    logic        scl;
    logic        pkt_valid;
    logic [6:0]  pkt_addr;
    logic [7:0]  pkt_command;
    logic [15:0] pkt_data;
    logic        crc_error;
    logic        format_error;
    logic        timeout_error;

    integer      seed = 50;
    int          err_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          pv_count = 0;
    int          fe_count = 0;
    logic        crc_err_seen;

    // Fields of the last accepted packet in the model
    smbus_byte_u model_addr;
    smbus_byte_u model_cmd;
    logic [15:0] model_data;

    smbus_pec_rx DUT (
        .clk           (clk),
        .rst_sync_n    (rst_sync_n),
        .sda           (sda),
        .scl           (scl),
        .pkt_valid     (pkt_valid),
        .pkt_addr      (pkt_addr),
        .pkt_command   (pkt_command),
        .pkt_data      (pkt_data),
        .crc_error     (crc_error),
        .format_error  (format_error),
        .timeout_error (timeout_error)
    );

    always #10 clk = ~clk;

    // Outcome pulses caught mid-cycle
    always @(negedge clk) begin
        if (pkt_valid) begin
            pv_count++;
            crc_err_seen = crc_error;
        end
        if (format_error) begin
            fe_count++;
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped at the cycle limit of %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            $display("ERR %s expected 0x%0h actual 0x%0h", name, exp, act);
            err_count++;
        end
    endtask

    // Address taken from the address view of the first byte
    task automatic check_addr(input string name, input smbus_byte_u exp, input logic [6:0] act);
        check_count++;
        if (act !== exp.a.addr) begin
            $display("ERR %s expected 0x%0h actual 0x%0h", name, exp.a.addr, act);
            err_count++;
        end
    endtask

    task automatic check_byte(input string name, input smbus_byte_u exp, input logic [7:0] act);
        check_count++;
        if (act !== exp.raw) begin
            $display("ERR %s expected 0x%0h actual 0x%0h", name, exp.raw, act);
            err_count++;
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        check_count++;
        if (act !== exp) begin
            $display("ERR %s expected 0x%0h actual 0x%0h", name, exp, act);
            err_count++;
        end
    endtask

    function automatic logic [7:0] rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // Serial CRC-8, one bit per step, MSB first
    function automatic logic [7:0] crc8_update(input logic [7:0] crc, input logic [7:0] b);
        logic [7:0] c;
        logic       fb;
        c = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = c[7] ^ b[i];
            c = {c[6:0], 1'b0};
            if (fb) begin
                c = c ^ CRC8_POLY;
            end
        end
        return c;
    endfunction

    // PEC over address, command, data low, data high
    function automatic logic [7:0] pec_of(input logic [7:0] a, input logic [7:0] c,
                                          input logic [15:0] d);
        logic [7:0] crc;
        crc = CRC8_INIT;
        crc = crc8_update(crc, a);
        crc = crc8_update(crc, c);
        crc = crc8_update(crc, d[7:0]);
        crc = crc8_update(crc, d[15:8]);
        return crc;
    endfunction

    // Drive point sits 2 ns past the rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // SDA moves only in the middle of the low phase
    task automatic drive_bit(input logic b);
        scl = 1'b0;
        wait_cycles(PHASE / 2);
        sda = b;
        wait_cycles(PHASE / 2);
        scl = 1'b1;
        wait_cycles(PHASE);
    endtask

    task automatic bus_start();
        sda = 1'b0;
        wait_cycles(PHASE);
    endtask

    task automatic send_byte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            drive_bit(b[i]);
        end
        // ACK slot, nobody pulls SDA low
        drive_bit(1'b1);
    endtask

    task automatic hold_scl_low(input int n);
        scl = 1'b0;
        wait_cycles(n);
    endtask

    // STOP on the pins, then collect what the DUT reported
    task automatic bus_stop(input bit expect_pulse, output bit got_pv, output bit got_fe);
        int pv0;
        int fe0;
        int waited;
        pv0 = pv_count;
        fe0 = fe_count;
        scl = 1'b0;
        wait_cycles(PHASE / 2);
        sda = 1'b0;
        wait_cycles(PHASE / 2);
        scl = 1'b1;
        wait_cycles(PHASE);
        sda = 1'b1;
        waited = 0;
        while (waited < 10 && pv_count == pv0 && fe_count == fe0) begin
            wait_cycles(1);
            waited++;
        end
        if (expect_pulse && pv_count == pv0 && fe_count == fe0) begin
            $display("No pkt_valid or format_error within 10 cycles after STOP");
            err_count++;
        end
        // Idle gap also catches any extra pulse
        wait_cycles(PHASE);
        got_pv = (pv_count != pv0);
        got_fe = (fe_count != fe0);
        if (pv_count - pv0 > 1 || fe_count - fe0 > 1 || (got_pv && got_fe)) begin
            $display("More than one outcome pulse after a single STOP");
            err_count++;
        end
    endtask

    task automatic run_write_word(input logic [7:0] pec_flip, input int hold_len,
                                  input bit do_start);
        smbus_byte_u addr_b;
        smbus_byte_u cmd_b;
        logic [15:0] data;
        logic [7:0]  pec;
        bit          got_pv;
        bit          got_fe;
        addr_b.raw = rand_byte();
        addr_b.a.rw = 1'b0;
        cmd_b.raw = rand_byte();
        data = {rand_byte(), rand_byte()};
        pec = pec_of(addr_b.raw, cmd_b.raw, data) ^ pec_flip;
        if (do_start) begin
            bus_start();
        end
        send_byte(addr_b.raw);
        send_byte(cmd_b.raw);
        if (hold_len > 0) begin
            // Stretch below the limit
            hold_scl_low(hold_len);
            check_flag("timeout_error", 1'b0, timeout_error);
        end
        send_byte(data[7:0]);
        send_byte(data[15:8]);
        send_byte(pec);
        bus_stop(1'b1, got_pv, got_fe);
        check_flag("pkt_valid", 1'b1, got_pv);
        check_flag("format_error", 1'b0, got_fe);
        check_flag("crc_error", pec_flip != 8'h00, crc_err_seen);
        check_addr("pkt_addr", addr_b, pkt_addr);
        check_byte("pkt_command", cmd_b, pkt_command);
        check_word("pkt_data", data, pkt_data);
        check_flag("timeout_error", 1'b0, timeout_error);
        model_addr = addr_b;
        model_cmd = cmd_b;
        model_data = data;
    endtask

    // Kind 0 has 4 bytes, kind 1 has 6 bytes, kind 2 sets the read bit
    task automatic run_bad_frame(input int kind);
        smbus_byte_u addr_b;
        logic [7:0]  cmd;
        logic [15:0] data;
        bit          got_pv;
        bit          got_fe;
        addr_b.raw = rand_byte();
        addr_b.a.rw = (kind == 2);
        cmd = rand_byte();
        data = {rand_byte(), rand_byte()};
        bus_start();
        send_byte(addr_b.raw);
        send_byte(cmd);
        send_byte(data[7:0]);
        send_byte(data[15:8]);
        if (kind != 0) begin
            send_byte(pec_of(addr_b.raw, cmd, data));
        end
        if (kind == 1) begin
            send_byte(rand_byte());
        end
        bus_stop(1'b1, got_pv, got_fe);
        check_flag("format_error", 1'b1, got_fe);
        check_flag("pkt_valid", 1'b0, got_pv);
        // Outputs keep the previous packet
        check_addr("pkt_addr", model_addr, pkt_addr);
        check_byte("pkt_command", model_cmd, pkt_command);
        check_word("pkt_data", model_data, pkt_data);
    endtask

    task automatic run_timeout_case();
        bit got_pv;
        bit got_fe;
        bus_start();
        send_byte(rand_byte() & 8'hFE);
        send_byte(rand_byte());
        hold_scl_low(LONG_HOLD);
        check_flag("timeout_error", 1'b1, timeout_error);
        bus_stop(1'b0, got_pv, got_fe);
        check_flag("pkt_valid", 1'b0, got_pv);
        check_flag("format_error", 1'b0, got_fe);
        check_flag("timeout_error", 1'b1, timeout_error);
        // Fresh START clears the level, then a normal packet follows
        bus_start();
        check_flag("timeout_error", 1'b0, timeout_error);
        run_write_word(8'h00, 0, 1'b0);
    endtask

    initial begin
        smbus_byte_u zero_b;
        logic [7:0]  flip;
        rst_sync_n = 1'b0;
        sda = 1'b1;
        scl = 1'b1;
        zero_b.raw = 8'h00;
        model_addr.raw = 8'h00;
        model_cmd.raw = 8'h00;
        model_data = 16'h0000;
        repeat (10) @(posedge clk);
        #2;
        rst_sync_n = 1'b1;
        wait_cycles(PHASE);

        // Idle after reset
        check_flag("pkt_valid", 1'b0, pkt_valid);
        check_flag("crc_error", 1'b0, crc_error);
        check_flag("format_error", 1'b0, format_error);
        check_flag("timeout_error", 1'b0, timeout_error);
        check_addr("pkt_addr", zero_b, pkt_addr);
        check_byte("pkt_command", zero_b, pkt_command);
        check_word("pkt_data", 16'h0000, pkt_data);

        for (int i = 0; i < 40; i++) begin
            run_write_word(8'h00, 0, 1'b1);
        end
        // Corrupted PEC byte
        for (int i = 0; i < 10; i++) begin
            flip = rand_byte();
            while (flip == 8'h00) begin
                flip = rand_byte();
            end
            run_write_word(flip, 0, 1'b1);
        end
        for (int i = 0; i < 2; i++) begin
            for (int k = 0; k < 3; k++) begin
                run_bad_frame(k);
            end
        end
        run_timeout_case();
        run_write_word(8'h00, SHORT_HOLD, 1'b1);

        $display("checks %0d errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
src/smbus_pkg.sv
src/smbus_line_sampler.sv
src/smbus_byte_framer.sv
src/smbus_timeout_monitor.sv
src/smbus_packet_assembler.sv
src/smbus_pec_rx.sv
dv/tb_smbus_pec_rx.sv
